/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := obstacle_map_tb
FILELIST := all.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
hdl/game_geometry_pkg.sv
hdl/obstacle_pkg.sv
hdl/mode_decoder.sv
hdl/obstacle_roller.sv
hdl/obstacle_field.sv
hdl/frame_window.sv
hdl/obstacle_map.sv
bench/obstacle_map_tb.sv

/* bench/obstacle_map_tb.sv */
/*
 * Obstacle map testbench.
 * Directed tests for idle clearing, obstacle shapes, scrolling,
 * spawn spacing, both pause modes and the return to idle.
 */

module obstacle_map_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import game_geometry_pkg::*;
    import obstacle_pkg::*;

    localparam int num_obstacles  = 10;
    localparam int scroll_speed   = 4;
    localparam int half_period    = 5;
    localparam int drive_delay    = 1;
    localparam int reset_cycles   = 16;
    localparam int appear_timeout = 60;
    localparam int clear_timeout  = 2;
    localparam logic [31:0] lcg_seed = 32'h255b346b;

    logic                          clk;
    logic                          rst_n;
    game_mode_t                    gamemode;
    screen_x_t [num_obstacles-1:0] obstacle_x_left;
    screen_x_t [num_obstacles-1:0] obstacle_x_right;
    screen_y_t [num_obstacles-1:0] obstacle_y_up;
    screen_y_t [num_obstacles-1:0] obstacle_y_down;

    int          error_count;
    int          frame_count;
    int          scroll_checks;
    int          spawn_checks;
    int          shown_count;
    int          last_spawn;
    bit          history_valid;
    logic [31:0] lcg_state;

    // outputs of the previous frame
    logic      [num_obstacles-1:0] prev_shown;
    screen_x_t [num_obstacles-1:0] prev_left;
    screen_x_t [num_obstacles-1:0] prev_right;
    screen_y_t [num_obstacles-1:0] prev_up;
    screen_y_t [num_obstacles-1:0] prev_down;

    obstacle_map dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .gamemode         (gamemode),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down)
    );

    always #(half_period) clk = ~clk;

    // ========================================
    // helpers
    // ========================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick_range(int lo, int hi);
        logic [31:0] r;
        r = lcg_next();
        return lo + int'(r[31:8] % (hi - lo + 1));
    endfunction

    function automatic bit all_hidden();
        bit hidden;
        hidden = 1'b1;
        for (int k = 0; k < num_obstacles; k++) begin
            if (int'(obstacle_x_left[k]) < screen_width) begin
                hidden = 1'b0;
            end
        end
        return hidden;
    endfunction

    // one frame, sampled and driven just after the edge
    task automatic next_frame();
        @(posedge clk);
        #(drive_delay);
        frame_count++;
    endtask

    task automatic report_mismatch(string name, int slot, int got, int expected);
        error_count++;
        $display("mismatch at %0t: %s[%0d] got %0d expected %0d",
                 $time, name, slot, got, expected);
    endtask

    task automatic report_range(string name, int slot, int got, int lo, int hi);
        error_count++;
        $display("mismatch at %0t: %s[%0d] got %0d expected %0d..%0d",
                 $time, name, slot, got, lo, hi);
    endtask

    task automatic report_failure(string what);
        error_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic check_hidden(int k);
        if (int'(obstacle_x_left[k]) != hidden_x) begin
            report_mismatch("obstacle_x_left", k, int'(obstacle_x_left[k]), hidden_x);
        end
        if (int'(obstacle_x_right[k]) != hidden_x) begin
            report_mismatch("obstacle_x_right", k, int'(obstacle_x_right[k]), hidden_x);
        end
        if (int'(obstacle_y_up[k]) != hidden_y) begin
            report_mismatch("obstacle_y_up", k, int'(obstacle_y_up[k]), hidden_y);
        end
        if (int'(obstacle_y_down[k]) != hidden_y) begin
            report_mismatch("obstacle_y_down", k, int'(obstacle_y_down[k]), hidden_y);
        end
    endtask

    task automatic check_all_hidden();
        for (int k = 0; k < num_obstacles; k++) begin
            check_hidden(k);
        end
    endtask

    task automatic check_shape(int k, int left, int right, int up, int down);
        if (right - left < min_width || right - left > max_width) begin
            report_range("obstacle width", k, right - left, min_width, max_width);
        end
        if (down - up < min_height || down - up > max_height) begin
            report_range("obstacle height", k, down - up, min_height, max_height);
        end
        if (up < upper_bound) begin
            report_range("obstacle_y_up", k, up, upper_bound, lower_bound);
        end
        if (down > lower_bound) begin
            report_range("obstacle_y_down", k, down, upper_bound, lower_bound);
        end
    endtask

    // new obstacle enters one step left of the screen edge
    task automatic check_new_spawn(int k, int left);
        int gap;
        if (left != screen_width - scroll_speed) begin
            report_mismatch("obstacle_x_left new", k, left, screen_width - scroll_speed);
        end
        if (last_spawn >= 0) begin
            if (int'(obstacle_x_left[last_spawn]) >= screen_width) begin
                report_failure("previous obstacle vanished before the next one appeared");
            end else begin
                gap = left - int'(obstacle_x_left[last_spawn]);
                spawn_checks++;
                if (gap < min_gap || gap > max_gap + scroll_speed) begin
                    report_range("spawn spacing", k, gap, min_gap, max_gap + scroll_speed);
                end
            end
        end
        last_spawn = k;
    endtask

    // shape, scroll and spawn checks on the current frame
    task automatic scan_frame();
        int left;
        int right;
        int up;
        int down;
        shown_count = 0;
        for (int k = 0; k < num_obstacles; k++) begin
            left  = int'(obstacle_x_left[k]);
            right = int'(obstacle_x_right[k]);
            up    = int'(obstacle_y_up[k]);
            down  = int'(obstacle_y_down[k]);
            if (left >= screen_width) begin
                check_hidden(k);
            end else begin
                shown_count++;
                check_shape(k, left, right, up, down);
                if (history_valid && prev_shown[k]) begin
                    scroll_checks++;
                    if (left != int'(prev_left[k]) - scroll_speed) begin
                        report_mismatch("obstacle_x_left", k, left,
                                        int'(prev_left[k]) - scroll_speed);
                    end
                    if (right - left != int'(prev_right[k]) - int'(prev_left[k])) begin
                        report_mismatch("obstacle width", k, right - left,
                                        int'(prev_right[k]) - int'(prev_left[k]));
                    end
                    if (up != int'(prev_up[k])) begin
                        report_mismatch("obstacle_y_up", k, up, int'(prev_up[k]));
                    end
                    if (down != int'(prev_down[k])) begin
                        report_mismatch("obstacle_y_down", k, down, int'(prev_down[k]));
                    end
                end else if (history_valid) begin
                    check_new_spawn(k, left);
                end
            end
            prev_shown[k] = left < screen_width;
            prev_left[k]  = obstacle_x_left[k];
            prev_right[k] = obstacle_x_right[k];
            prev_up[k]    = obstacle_y_up[k];
            prev_down[k]  = obstacle_y_down[k];
        end
        history_valid = 1'b1;
    endtask

    // first run sample only seeds the history
    task automatic start_run();
        gamemode      = mode_run;
        history_valid = 1'b0;
        last_spawn    = -1;
    endtask

    task automatic wait_visible();
        int n;
        n           = 0;
        shown_count = 0;
        while (shown_count == 0 && n < appear_timeout) begin
            next_frame();
            scan_frame();
            n++;
        end
        if (shown_count == 0) begin
            report_failure("no obstacle became visible within 60 run frames");
        end
    endtask

    // ========================================
    // tests
    // ========================================
    task automatic test_reset_idle();
        gamemode = mode_idle;
        check_all_hidden();
        repeat (20) begin
            next_frame();
            check_all_hidden();
        end
    endtask

    task automatic test_run_shapes();
        int frames;
        frames = pick_range(200, 400);
        start_run();
        wait_visible();
        repeat (frames) begin
            next_frame();
            scan_frame();
        end
        if (scroll_checks == 0 || spawn_checks == 0) begin
            report_failure("run phase saw no scrolling or no obstacle pair");
        end
    endtask

    task automatic test_pause(game_mode_t mode);
        int                            hold;
        screen_x_t [num_obstacles-1:0] held_left;
        screen_x_t [num_obstacles-1:0] held_right;
        screen_y_t [num_obstacles-1:0] held_up;
        screen_y_t [num_obstacles-1:0] held_down;
        hold     = pick_range(5, 30);
        gamemode = mode;
        for (int n = 1; n <= hold; n++) begin
            next_frame();
            if (n == 2) begin
                held_left  = obstacle_x_left;
                held_right = obstacle_x_right;
                held_up    = obstacle_y_up;
                held_down  = obstacle_y_down;
            end else if (n > 2) begin
                for (int k = 0; k < num_obstacles; k++) begin
                    if (obstacle_x_left[k] != held_left[k]) begin
                        report_mismatch("obstacle_x_left", k, int'(obstacle_x_left[k]),
                                        int'(held_left[k]));
                    end
                    if (obstacle_x_right[k] != held_right[k]) begin
                        report_mismatch("obstacle_x_right", k, int'(obstacle_x_right[k]),
                                        int'(held_right[k]));
                    end
                    if (obstacle_y_up[k] != held_up[k]) begin
                        report_mismatch("obstacle_y_up", k, int'(obstacle_y_up[k]),
                                        int'(held_up[k]));
                    end
                    if (obstacle_y_down[k] != held_down[k]) begin
                        report_mismatch("obstacle_y_down", k, int'(obstacle_y_down[k]),
                                        int'(held_down[k]));
                    end
                end
            end
        end
        // resume and keep checking the motion
        start_run();
        repeat (pick_range(20, 60)) begin
            next_frame();
            scan_frame();
        end
    endtask

    task automatic test_return_idle();
        int n;
        gamemode = mode_idle;
        n        = 0;
        while (!all_hidden() && n < clear_timeout) begin
            next_frame();
            n++;
        end
        if (!all_hidden()) begin
            report_failure("obstacles still shown 2 frames after switching to idle");
        end
        repeat (5) begin
            next_frame();
            check_all_hidden();
        end
        start_run();
        wait_visible();
        repeat (100) begin
            next_frame();
            scan_frame();
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        gamemode      = mode_idle;
        error_count   = 0;
        frame_count   = 0;
        scroll_checks = 0;
        spawn_checks  = 0;
        shown_count   = 0;
        last_spawn    = -1;
        history_valid = 1'b0;
        lcg_state     = lcg_seed;
        prev_shown    = '0;
        prev_left     = '0;
        prev_right    = '0;
        prev_up       = '0;
        prev_down     = '0;

        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        rst_n = 1'b1;

        test_reset_idle();
        test_run_shapes();
        test_pause(mode_pause_a);
        test_pause(mode_pause_b);
        test_return_idle();

        $display("frames %0d, scroll checks %0d, spawn checks %0d, errors %0d",
                 frame_count, scroll_checks, spawn_checks, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* hdl/frame_window.sv */
/*
 * Frame window.
 * Clips each slot to the visible screen and registers its edges,
 * or the off-screen sentinels for a hidden slot.
 */

module frame_window #(
    parameter int num_obstacles = 10
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [num_obstacles-1:0]                          slot_active,
    input  game_geometry_pkg::pos_x_t [num_obstacles-1:0]     slot_x,
    input  game_geometry_pkg::screen_y_t [num_obstacles-1:0]  slot_y,
    input  obstacle_pkg::span_t [num_obstacles-1:0]           slot_width,
    input  obstacle_pkg::span_t [num_obstacles-1:0]           slot_height,
    output game_geometry_pkg::screen_x_t [num_obstacles-1:0]  obstacle_x_left,
    output game_geometry_pkg::screen_x_t [num_obstacles-1:0]  obstacle_x_right,
    output game_geometry_pkg::screen_y_t [num_obstacles-1:0]  obstacle_y_up,
    output game_geometry_pkg::screen_y_t [num_obstacles-1:0]  obstacle_y_down
);

    import game_geometry_pkg::*;

    logic [num_obstacles-1:0] shown;

    // left edge inside the screen
    always_comb begin
        for (int k = 0; k < num_obstacles; k++) begin
            shown[k] = slot_active[k] && int'(slot_x[k]) >= 0
                       && int'(slot_x[k]) < screen_width;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < num_obstacles; k++) begin
                obstacle_x_left[k]  <= screen_x_t'(hidden_x);
                obstacle_x_right[k] <= screen_x_t'(hidden_x);
                obstacle_y_up[k]    <= screen_y_t'(hidden_y);
                obstacle_y_down[k]  <= screen_y_t'(hidden_y);
            end
        end else begin
            for (int k = 0; k < num_obstacles; k++) begin
                if (shown[k]) begin
                    obstacle_x_left[k]  <= screen_x_t'(slot_x[k]);
                    // right edge may run past the screen, the renderer clips it
                    obstacle_x_right[k] <= screen_x_t'(int'(slot_x[k]) + int'(slot_width[k]));
                    obstacle_y_up[k]    <= slot_y[k];
                    obstacle_y_down[k]  <= screen_y_t'(int'(slot_y[k]) + int'(slot_height[k]));
                end else begin
                    obstacle_x_left[k]  <= screen_x_t'(hidden_x);
                    obstacle_x_right[k] <= screen_x_t'(hidden_x);
                    obstacle_y_up[k]    <= screen_y_t'(hidden_y);
                    obstacle_y_down[k]  <= screen_y_t'(hidden_y);
                end
            end
        end
    end

endmodule

/* hdl/game_geometry_pkg.sv */
/*
 * Playfield geometry for the obstacle generator.
 * Screen bounds, hidden-slot sentinels and coordinate types.
 */

package game_geometry_pkg;

    // ========================================
    // screen and play area bounds
    // ========================================
    localparam int screen_width = 640;
    localparam int upper_bound  = 20;
    localparam int lower_bound  = 460;

    // sentinels for a slot that is not on screen
    localparam int hidden_x = 700;
    localparam int hidden_y = 500;

    // ========================================
    // coordinate types
    // ========================================
    // stored slot column, goes negative while leaving the screen
    typedef logic signed [10:0] pos_x_t;

    // output column
    typedef logic [9:0] screen_x_t;

    // row, stored and output
    typedef logic [8:0] screen_y_t;

endpackage

/* hdl/mode_decoder.sv */
/*
 * Game mode decoder.
 * Turns the mode level into per-frame clear and step controls.
 */

module mode_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  obstacle_pkg::game_mode_t gamemode,
    output logic                    field_clear,
    output logic                    run_step
);

    import obstacle_pkg::*;

    game_mode_t prev_mode;

    // one frame of mode history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_mode <= mode_idle;
        end else begin
            prev_mode <= gamemode;
        end
    end

    always_comb begin
        field_clear = 1'b0;
        run_step    = 1'b0;
        case (gamemode)
            mode_idle: begin
                field_clear = 1'b1;
            end
            mode_run: begin
                // first run frame after idle only clears
                if (prev_mode == mode_idle) begin
                    field_clear = 1'b1;
                end else begin
                    run_step = 1'b1;
                end
            end
            mode_pause_a, mode_pause_b: begin
                // field holds
                field_clear = 1'b0;
                run_step    = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/obstacle_field.sv */
/*
 * Obstacle field.
 * Slot registers and spawn distance. Scrolls active slots, drops
 * those that left the screen and spawns into the lowest free slot.
 */

module obstacle_field #(
    parameter int num_obstacles = 10,
    parameter int scroll_speed  = 4
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              field_clear,
    input  logic                                              run_step,
    input  obstacle_pkg::span_t                               new_width,
    input  obstacle_pkg::span_t                               new_height,
    input  game_geometry_pkg::screen_y_t                      new_y,
    input  obstacle_pkg::span_t                               new_gap,
    output logic [num_obstacles-1:0]                          slot_active,
    output game_geometry_pkg::pos_x_t [num_obstacles-1:0]     slot_x,
    output game_geometry_pkg::screen_y_t [num_obstacles-1:0]  slot_y,
    output obstacle_pkg::span_t [num_obstacles-1:0]           slot_width,
    output obstacle_pkg::span_t [num_obstacles-1:0]           slot_height
);

    import game_geometry_pkg::*;
    import obstacle_pkg::*;

    localparam int idx_w = (num_obstacles > 1) ? $clog2(num_obstacles) : 1;

    pos_x_t                     next_spawn_x;
    pos_x_t [num_obstacles-1:0] moved_x;
    logic   [num_obstacles-1:0] gone;
    logic                       free_found;
    logic   [idx_w-1:0]         free_idx;
    logic                       spawn_due;
    logic                       spawn_go;

    // ========================================
    // per-slot move and removal
    // ========================================
    always_comb begin
        for (int i = 0; i < num_obstacles; i++) begin
            moved_x[i] = pos_x_t'(int'(slot_x[i]) - scroll_speed);
            // right edge at or past column zero after the move
            gone[i] = (int'(slot_x[i]) - scroll_speed + int'(slot_width[i])) <= 0;
        end
    end

    // lowest free slot wins, so scan downwards
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = num_obstacles - 1; i >= 0; i--) begin
            if (!slot_active[i]) begin
                free_found = 1'b1;
                free_idx   = idx_w'(i);
            end
        end
    end

    assign spawn_due = int'(next_spawn_x) <= screen_width;
    assign spawn_go  = spawn_due && free_found;

    // ========================================
    // control state
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_active  <= '0;
            next_spawn_x <= pos_x_t'(screen_width + min_gap);
        end else if (field_clear) begin
            slot_active  <= '0;
            next_spawn_x <= pos_x_t'(screen_width + min_gap);
        end else if (run_step) begin
            for (int i = 0; i < num_obstacles; i++) begin
                if (slot_active[i] && gone[i]) begin
                    slot_active[i] <= 1'b0;
                end
            end
            if (spawn_go) begin
                slot_active[free_idx] <= 1'b1;
                next_spawn_x          <= pos_x_t'(screen_width + int'(new_gap));
            end else if (!spawn_due) begin
                next_spawn_x <= pos_x_t'(int'(next_spawn_x) - scroll_speed);
            end
            // due but no free slot: distance holds until one frees up
        end
    end

    // ========================================
    // slot payload
    // ========================================
    always_ff @(posedge clk) begin
        if (run_step) begin
            for (int i = 0; i < num_obstacles; i++) begin
                if (slot_active[i]) begin
                    slot_x[i] <= moved_x[i];
                end
            end
            if (spawn_go) begin
                slot_x[free_idx]      <= pos_x_t'(screen_width);
                slot_y[free_idx]      <= new_y;
                slot_width[free_idx]  <= new_width;
                slot_height[free_idx] <= new_height;
            end
        end
    end

endmodule

/* hdl/obstacle_map.sv */
/*
 * Obstacle map, top level of the obstacle generator.
 * Mode decode, roller and slot field, then the screen window.
 */

module obstacle_map #(
    parameter int num_obstacles = 10,
    parameter int scroll_speed  = 4
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  obstacle_pkg::game_mode_t                          gamemode,
    output game_geometry_pkg::screen_x_t [num_obstacles-1:0]  obstacle_x_left,
    output game_geometry_pkg::screen_x_t [num_obstacles-1:0]  obstacle_x_right,
    output game_geometry_pkg::screen_y_t [num_obstacles-1:0]  obstacle_y_up,
    output game_geometry_pkg::screen_y_t [num_obstacles-1:0]  obstacle_y_down
);

    import game_geometry_pkg::*;
    import obstacle_pkg::*;

    logic                          field_clear;
    logic                          run_step;
    span_t                         new_width;
    span_t                         new_height;
    span_t                         new_gap;
    screen_y_t                     new_y;
    logic      [num_obstacles-1:0] slot_active;
    pos_x_t    [num_obstacles-1:0] slot_x;
    screen_y_t [num_obstacles-1:0] slot_y;
    span_t     [num_obstacles-1:0] slot_width;
    span_t     [num_obstacles-1:0] slot_height;

    // ========================================
    // decode
    // ========================================
    mode_decoder decoder_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .gamemode    (gamemode),
        .field_clear (field_clear),
        .run_step    (run_step)
    );

    // ========================================
    // execute
    // ========================================
    obstacle_roller roller_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_width  (new_width),
        .new_height (new_height),
        .new_gap    (new_gap),
        .new_y      (new_y)
    );

    obstacle_field #(
        .num_obstacles (num_obstacles),
        .scroll_speed  (scroll_speed)
    ) field_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .field_clear (field_clear),
        .run_step    (run_step),
        .new_width   (new_width),
        .new_height  (new_height),
        .new_y       (new_y),
        .new_gap     (new_gap),
        .slot_active (slot_active),
        .slot_x      (slot_x),
        .slot_y      (slot_y),
        .slot_width  (slot_width),
        .slot_height (slot_height)
    );

    // ========================================
    // result, one frame behind the field
    // ========================================
    frame_window #(
        .num_obstacles (num_obstacles)
    ) window_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .slot_active      (slot_active),
        .slot_x           (slot_x),
        .slot_y           (slot_y),
        .slot_width       (slot_width),
        .slot_height      (slot_height),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down)
    );

endmodule

/* hdl/obstacle_pkg.sv */
/*
 * Obstacle definitions.
 * Game mode encoding, random word type and size and gap limits.
 */

package obstacle_pkg;

    // ========================================
    // game mode from the game controller
    // ========================================
    typedef enum logic [1:0] {
        mode_idle    = 2'd0,
        mode_run     = 2'd1,
        mode_pause_a = 2'd2,
        mode_pause_b = 2'd3
    } game_mode_t;

    typedef logic [31:0] rand_word_t;

    // width, height or gap of one obstacle
    typedef logic [7:0] span_t;

    // ========================================
    // drawing limits, all inclusive
    // ========================================
    localparam int min_width  = 20;
    localparam int max_width  = 80;
    localparam int min_height = 20;
    localparam int max_height = 150;
    localparam int min_gap    = 80;
    localparam int max_gap    = 180;

    localparam rand_word_t lfsr_seed = 32'h6b3a_91c5;

endpackage

/* hdl/obstacle_roller.sv */
/*
 * Obstacle roller.
 * Free-running 32-bit Galois LFSR, mapped onto width, height,
 * vertical position and gap of the next obstacle.
 */

module obstacle_roller (
    input  logic                         clk,
    input  logic                         rst_n,
    output obstacle_pkg::span_t          new_width,
    output obstacle_pkg::span_t          new_height,
    output obstacle_pkg::span_t          new_gap,
    output game_geometry_pkg::screen_y_t new_y
);

    import obstacle_pkg::*;
    import game_geometry_pkg::*;

    // x^32 + x^22 + x^2 + x + 1, right-shifting form
    localparam rand_word_t lfsr_taps = 32'h8020_0003;

    rand_word_t lfsr_q;
    int         y_range;

    // ========================================
    // LFSR, one step per frame
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= lfsr_seed;
        end else begin
            lfsr_q <= {1'b0, lfsr_q[31:1]} ^ ({32{lfsr_q[0]}} & lfsr_taps);
        end
    end

    // ========================================
    // draws
    // ========================================
    // disjoint fields, each a little wider than its range;
    // y gets ten bits so the whole legal range is reachable
    always_comb begin
        new_width  = span_t'(min_width + int'(lfsr_q[6:0]) % (max_width - min_width + 1));
        new_gap    = span_t'(min_gap + int'(lfsr_q[13:7]) % (max_gap - min_gap + 1));
        new_height = span_t'(min_height
                             + int'(lfsr_q[21:14]) % (max_height - min_height + 1));
    end

    // top edge range shrinks with the drawn height
    always_comb begin
        y_range = lower_bound - int'(new_height) - upper_bound + 1;
        new_y   = screen_y_t'(upper_bound + int'(lfsr_q[31:22]) % y_range);
    end

endmodule
